// ==== filelist.f ====
rtl/pgwr_pkg.sv
rtl/entry_counter.sv
rtl/list_ptr_regs.sv
rtl/wr_resp_tracker.sv
rtl/tbl_wr_builder.sv
rtl/pgwr_fsm.sv
rtl/pgwr_mngr.sv
tests/tb_axi_mem.sv
tests/tb_pgwr_mngr.sv

// ==== rtl/entry_counter.sv ====
// entry index of the init passes, first entry is 1
// last_entry compares against the table chosen by is_list
`timescale 1ns/1ps

module entry_counter (
	input  logic           clk_i,
	input  logic           rst_ni,
	input  logic           cnt_start,
	input  logic           cnt_step,
	input  logic           is_list,
	output pgwr_pkg::ptr_t entry_idx,
	output logic           last_entry
);
	import pgwr_pkg::*;

	ptr_t last_idx; // final entry of the current pass

	assign last_idx   = is_list ? ptr_t'(LIST_ENTRY_CNT) : ptr_t'(ATT_ENTRY_CNT);
	assign last_entry = (entry_idx == last_idx);

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			entry_idx <= NULL_PTR;
		end else if (cnt_start) begin
			entry_idx <= ptr_t'(1);
		end else if (cnt_step) begin
			entry_idx <= entry_idx + 1'b1; // one step per data beat
		end
	end

endmodule

// ==== rtl/list_ptr_regs.sv ====
// head and tail of the free and uncompressed lists, NULL_PTR when empty
// push takes the current free head as the moved entry, so pop and push
// may strobe in the same cycle
`timescale 1ns/1ps

module list_ptr_regs (
	input  logic           clk_i,
	input  logic           rst_ni,
	input  logic           init_list_end,
	input  logic           pop_free,
	input  logic           empty_free,
	input  logic           push_uncomp,
	input  logic           first_uncomp,
	input  pgwr_pkg::ptr_t new_head,
	output pgwr_pkg::ptr_t free_head,
	output pgwr_pkg::ptr_t free_tail,
	output pgwr_pkg::ptr_t uncomp_head,
	output pgwr_pkg::ptr_t uncomp_tail
);
	import pgwr_pkg::*;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			free_head <= NULL_PTR;
			free_tail <= NULL_PTR;
		end else if (init_list_end) begin // one long list 1..LIST_ENTRY_CNT
			free_head <= ptr_t'(1);
			free_tail <= ptr_t'(LIST_ENTRY_CNT);
		end else if (empty_free) begin    // last free entry handed out
			free_head <= NULL_PTR;
			free_tail <= NULL_PTR;
		end else if (pop_free) begin
			free_head <= new_head;         // next of the old head
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			uncomp_head <= NULL_PTR;
			uncomp_tail <= NULL_PTR;
		end else if (push_uncomp) begin
			uncomp_tail <= free_head; // old value, before any pop lands
			if (first_uncomp) uncomp_head <= free_head;
		end
	end

endmodule

// ==== rtl/pgwr_fsm.sv ====
// sequences the init passes and the 2 to 4 writes of an allocation
// one write open at a time, awvalid and wvalid never overlap
// list pointers stay stable until the last beat of an allocation
`timescale 1ns/1ps

module pgwr_fsm (
	input  logic                  clk_i,
	input  logic                  rst_ni,
	input  logic                  init_att,
	input  logic                  init_list,
	input  logic                  upd_valid,
	input  pgwr_pkg::att_id_t     upd_att_id,
	input  pgwr_pkg::ppn_t        upd_way,
	input  pgwr_pkg::ptr_t        upd_next,
	input  logic                  awready,
	input  logic                  wready,
	input  pgwr_pkg::ptr_t        entry_idx,
	input  logic                  last_entry,
	input  logic                  drained,
	input  pgwr_pkg::ptr_t        free_head,
	input  pgwr_pkg::ptr_t        free_tail,
	input  pgwr_pkg::ptr_t        uncomp_tail,
	output logic                  awvalid,
	output logic                  wvalid,
	output logic                  ready,
	output logic                  upd_done,
	output logic                  init_att_done,
	output logic                  init_list_done,
	output pgwr_pkg::pgwr_state_e state,
	output logic                  ld_pkt,
	output logic                  cnt_start,
	output logic                  cnt_step,
	output pgwr_pkg::att_id_t     lat_att_id,
	output pgwr_pkg::ppn_t        lat_way,
	output pgwr_pkg::ptr_t        lat_next,
	output logic                  pop_free,
	output logic                  empty_free,
	output logic                  push_uncomp,
	output logic                  first_uncomp
);
	import pgwr_pkg::*;

	pgwr_state_e state_d;
	logic        awvalid_d;
	logic        wvalid_d;
	logic        op_att_q;  // att init in flight
	logic        op_list_q; // list init in flight, neither flag means allocation
	logic        op_att_d;
	logic        op_list_d;
	logic        lat_en;
	logic        one_free;  // free list down to its head
	logic        last_wr;   // final data beat of an allocation
	logic        drain_end;

	assign ready        = (state == IDLE);
	assign one_free     = (free_head == free_tail);
	assign first_uncomp = (uncomp_tail == NULL_PTR); // no link write needed
	assign last_wr      = wready && ((state == DST_LINK_W) || (state == DST_SELF_W && first_uncomp));
	// pointer strobes all land on the last beat, old free head is the moved entry
	assign push_uncomp  = last_wr;
	assign pop_free     = last_wr && !one_free;
	assign empty_free   = last_wr && one_free;
	assign drain_end    = (state == WAIT_BRESP) && drained;

	always_comb begin
		state_d   = state;
		awvalid_d = awvalid;
		wvalid_d  = wvalid;
		op_att_d  = op_att_q;
		op_list_d = op_list_q;
		ld_pkt    = 1'b0;
		cnt_start = 1'b0;
		cnt_step  = 1'b0;
		lat_en    = 1'b0;
		unique case (state)
			IDLE: begin
				if (init_att && !init_att_done) begin // att init has priority
					state_d   = INIT_ATT_AW;
					op_att_d  = 1'b1;
					op_list_d = 1'b0;
					cnt_start = 1'b1;
				end else if (init_list && !init_list_done) begin
					state_d   = INIT_LIST_AW;
					op_att_d  = 1'b0;
					op_list_d = 1'b1;
					cnt_start = 1'b1;
				end else if (upd_valid) begin
					state_d   = ATT_UPD_AW;
					op_att_d  = 1'b0;
					op_list_d = 1'b0;
					lat_en    = 1'b1;
				end
			end
			INIT_ATT_AW, INIT_LIST_AW, ATT_UPD_AW, SRC_POP_AW, DST_SELF_AW, DST_LINK_AW: begin
				if (!awvalid) begin // build packet, address goes out next cycle
					ld_pkt    = 1'b1;
					awvalid_d = 1'b1;
				end else if (awready) begin
					awvalid_d = 1'b0;
					wvalid_d  = 1'b1;
					state_d   = pgwr_state_e'(state + 4'd1);
				end
			end
			INIT_ATT_W, INIT_LIST_W: begin
				if (wready) begin
					wvalid_d = 1'b0;
					cnt_step = 1'b1;
					state_d  = last_entry ? WAIT_BRESP : pgwr_state_e'(state - 4'd1);
				end
			end
			ATT_UPD_W: begin
				if (wready) begin
					wvalid_d = 1'b0;
					state_d  = one_free ? DST_SELF_AW : SRC_POP_AW; // no pop of a lone head
				end
			end
			SRC_POP_W: begin
				if (wready) begin
					wvalid_d = 1'b0;
					state_d  = DST_SELF_AW;
				end
			end
			DST_SELF_W, DST_LINK_W: begin
				if (wready) begin
					wvalid_d = 1'b0;
					state_d  = last_wr ? WAIT_BRESP : DST_LINK_AW;
				end
			end
			WAIT_BRESP: if (drained) state_d = IDLE;
			default:    state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state          <= IDLE;
			awvalid        <= 1'b0;
			wvalid         <= 1'b0;
			op_att_q       <= 1'b0;
			op_list_q      <= 1'b0;
			upd_done       <= 1'b0;
			init_att_done  <= 1'b0;
			init_list_done <= 1'b0;
		end else begin
			state     <= state_d;
			awvalid   <= awvalid_d;
			wvalid    <= wvalid_d;
			op_att_q  <= op_att_d;
			op_list_q <= op_list_d;
			upd_done  <= drain_end && !op_att_q && !op_list_q; // one cycle pulse
			if (drain_end && op_att_q) init_att_done <= 1'b1; // sticky
			if (drain_end && op_list_q) init_list_done <= 1'b1;
		end
	end

	// request fields sampled in the accept cycle
	always_ff @(posedge clk_i) begin
		if (lat_en) begin
			lat_att_id <= upd_att_id;
			lat_way    <= upd_way;
			lat_next   <= upd_next;
		end
	end

	a_aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
		awvalid && !awready |=> awvalid);
	a_one_phase: assert property (@(posedge clk_i) disable iff (!rst_ni)
		!(awvalid && wvalid));
	// counter must already hold a real entry when an init packet is built
	a_cnt_live: assert property (@(posedge clk_i) disable iff (!rst_ni)
		ld_pkt && (state == INIT_ATT_AW || state == INIT_LIST_AW) |-> entry_idx != NULL_PTR);

endmodule

// ==== rtl/pgwr_mngr.sv ====
// page-table write manager top, ATT/list init and free-to-uncomp allocation
// writes go out on a single-beat AXI-style write channel, one at a time
// upd_next must be the next pointer of the current free head
`timescale 1ns/1ps

module pgwr_mngr (
	input  logic              clk_i,
	input  logic              rst_ni,
	input  logic              init_att,
	input  logic              init_list,
	input  logic              upd_valid,
	input  pgwr_pkg::att_id_t upd_att_id,
	input  pgwr_pkg::ppn_t    upd_way,
	input  pgwr_pkg::ptr_t    upd_next,
	output logic              ready,
	output logic              upd_done,
	output logic              init_att_done,
	output logic              init_list_done,
	output logic              bus_error,
	output logic              awvalid,
	input  logic              awready,
	output pgwr_pkg::addr_t   awaddr,
	output logic              wvalid,
	input  logic              wready,
	output pgwr_pkg::line_t   wdata,
	output pgwr_pkg::strb_t   wstrb,
	input  logic              bvalid,
	input  logic [1:0]        bresp,
	output pgwr_pkg::ptr_t    free_head,
	output pgwr_pkg::ptr_t    free_tail,
	output pgwr_pkg::ptr_t    uncomp_head,
	output pgwr_pkg::ptr_t    uncomp_tail
);
	import pgwr_pkg::*;

	pgwr_state_e state;
	logic        ld_pkt, cnt_start, cnt_step, last_entry, drained;
	logic        pop_free, empty_free, push_uncomp, first_uncomp;
	logic        is_list;       // list init pass active
	logic        init_list_end; // last list init beat accepted
	ptr_t        entry_idx, lat_next;
	att_id_t     lat_att_id;
	ppn_t        lat_way;

	assign is_list       = (state == INIT_LIST_AW) || (state == INIT_LIST_W);
	assign init_list_end = (state == INIT_LIST_W) && wready && last_entry;

	pgwr_fsm u_fsm (.*);

	entry_counter u_cnt (.*);

	tbl_wr_builder u_bld (.*);

	list_ptr_regs u_ptrs (
		.clk_i, .rst_ni, .init_list_end, .pop_free, .empty_free, .push_uncomp,
		.first_uncomp, .new_head(lat_next), .free_head, .free_tail, .uncomp_head,
		.uncomp_tail
	);

	wr_resp_tracker u_resp (.*);

endmodule

// ==== rtl/pgwr_pkg.sv ====
// geometry, entry layouts and state codes shared by the page-table write manager
// entry indices count from 1, index 0 is the null pointer of every list
// table sizes are fixed here and no module overrides them
package pgwr_pkg;

	localparam int PTR_W = 24; // list and att index width
	localparam int WAY_W = 32; // physical page number width
	localparam int STS_W = 2;

	typedef logic [63:0]      addr_t;   // byte address
	typedef logic [511:0]     line_t;   // one cache line
	typedef logic [63:0]      strb_t;   // byte strobe of a line
	typedef logic [PTR_W-1:0] ptr_t;    // list entry index
	typedef logic [PTR_W-1:0] att_id_t; // att entry index
	typedef logic [WAY_W-1:0] ppn_t;

	localparam int LINE_BYTES     = 64;
	localparam int ATT_ENTRY_CNT  = 32;
	localparam int LIST_ENTRY_CNT = 16;
	localparam int ATT_PER_LINE   = 8;  // 8 byte att entries
	localparam int LST_PER_LINE   = 4;  // 16 byte list entries

	localparam addr_t ATT_BASE  = 64'h1000;
	localparam addr_t LIST_BASE = 64'h2000;
	localparam ppn_t  PPN_BASE  = 32'h0008_0000; // page of list entry 1
	localparam ptr_t  NULL_PTR  = '0;

	// att entry
	localparam int STS_LSB = 0;
	localparam int WAY_LSB = 2;

	// list entry, upper 24 bits reserved
	localparam int NEXT_LSB  = 0;
	localparam int PREV_LSB  = 24;
	localparam int ATTID_LSB = 48;
	localparam int WAY_LSB_L = 72;

	localparam logic [STS_W-1:0] STS_DALLOC = 2'd0;
	localparam logic [STS_W-1:0] STS_UNCOMP = 2'd1;

	// every W state is encoded as its AW state plus one
	typedef enum logic [3:0] {
		IDLE         = 4'd0,
		INIT_ATT_AW  = 4'd1,
		INIT_ATT_W   = 4'd2,
		INIT_LIST_AW = 4'd3,
		INIT_LIST_W  = 4'd4,
		ATT_UPD_AW   = 4'd5,
		ATT_UPD_W    = 4'd6,
		SRC_POP_AW   = 4'd7,
		SRC_POP_W    = 4'd8,
		DST_SELF_AW  = 4'd9,
		DST_SELF_W   = 4'd10,
		DST_LINK_AW  = 4'd11,
		DST_LINK_W   = 4'd12,
		WAIT_BRESP   = 4'd13
	} pgwr_state_e;

endpackage

// ==== rtl/tbl_wr_builder.sv ====
// forms address, data line and byte strobe of each table write
// only the bytes of changed fields are strobed, other entries in the line untouched
// outputs load on ld_pkt and hold through both phases of the write
`timescale 1ns/1ps

module tbl_wr_builder (
	input  logic                  clk_i,
	input  logic                  rst_ni,
	input  logic                  ld_pkt,
	input  pgwr_pkg::pgwr_state_e state,
	input  pgwr_pkg::ptr_t        entry_idx,
	input  pgwr_pkg::att_id_t     lat_att_id,
	input  pgwr_pkg::ppn_t        lat_way,
	input  pgwr_pkg::ptr_t        lat_next,
	input  pgwr_pkg::ptr_t        free_head,
	input  pgwr_pkg::ptr_t        uncomp_tail,
	output pgwr_pkg::addr_t       awaddr,
	output pgwr_pkg::line_t       wdata,
	output pgwr_pkg::strb_t       wstrb
);
	import pgwr_pkg::*;

	logic         is_att;   // att table, else list table
	ptr_t         idx;      // entry written, counts from 1
	ptr_t         ofs;      // entry position from 0
	logic [127:0] ent;      // entry image, att uses the low 64 bits
	logic [15:0]  ent_strb;
	int unsigned  per_line;
	int unsigned  slot;
	int unsigned  ent_bits;
	addr_t        addr_d;
	line_t        data_d;
	strb_t        strb_d;

	always_comb begin
		is_att   = 1'b0;
		idx      = NULL_PTR;
		ent      = '0;
		ent_strb = '0;
		unique case (state)
			INIT_ATT_AW: begin
				is_att   = 1'b1;
				idx      = entry_idx;
				ent[STS_LSB +: STS_W] = STS_DALLOC; // way stays zero
				ent_strb = 16'h00ff;
			end
			INIT_LIST_AW: begin
				idx = entry_idx;
				ent[NEXT_LSB +: PTR_W] = (entry_idx == ptr_t'(LIST_ENTRY_CNT)) ?
					NULL_PTR : entry_idx + 1'b1;
				ent[PREV_LSB +: PTR_W]  = entry_idx - 1'b1; // entry 1 gets null
				ent[WAY_LSB_L +: WAY_W] = PPN_BASE + ppn_t'(entry_idx) - 1'b1;
				ent_strb = 16'hffff; // whole entry incl att id
			end
			ATT_UPD_AW: begin
				is_att   = 1'b1;
				idx      = lat_att_id;
				ent[STS_LSB +: STS_W] = STS_UNCOMP;
				ent[WAY_LSB +: WAY_W] = lat_way;
				ent_strb = 16'h00ff;
			end
			SRC_POP_AW: begin // new free head loses its prev
				idx      = lat_next;
				ent[PREV_LSB +: PTR_W] = NULL_PTR;
				ent_strb = 16'h0007 << (PREV_LSB / 8);
			end
			DST_SELF_AW: begin // moved entry becomes uncomp tail
				idx = free_head;
				ent[NEXT_LSB +: PTR_W]  = NULL_PTR;
				ent[PREV_LSB +: PTR_W]  = uncomp_tail;
				ent[ATTID_LSB +: PTR_W] = lat_att_id;
				ent_strb = 16'h01ff; // next, prev, att id
			end
			DST_LINK_AW: begin
				idx      = uncomp_tail;
				ent[NEXT_LSB +: PTR_W] = free_head;
				ent_strb = 16'h0007 << (NEXT_LSB / 8);
			end
			default: ;
		endcase

		ofs      = idx - 1'b1;
		per_line = is_att ? ATT_PER_LINE : LST_PER_LINE;
		ent_bits = LINE_BYTES * 8 / per_line;
		slot     = int'(ofs) % per_line;
		addr_d   = (is_att ? ATT_BASE : LIST_BASE) +
			addr_t'(int'(ofs) / per_line) * LINE_BYTES;
		data_d   = line_t'(ent) << (slot * ent_bits);
		strb_d   = strb_t'(ent_strb) << (slot * ent_bits / 8);
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			awaddr <= '0;
			wdata  <= '0;
			wstrb  <= '0;
		end else if (ld_pkt) begin
			awaddr <= addr_d;
			wdata  <= data_d;
			wstrb  <= strb_d;
		end
	end

endmodule

// ==== rtl/wr_resp_tracker.sv ====
// counts writes between address handshake and response, up to 127
// bus_error is sticky until reset
`timescale 1ns/1ps

module wr_resp_tracker (
	input  logic       clk_i,
	input  logic       rst_ni,
	input  logic       awvalid,
	input  logic       awready,
	input  logic       bvalid,
	input  logic [1:0] bresp,
	output logic       drained,
	output logic       bus_error
);
	logic [6:0] out_cnt; // writes awaiting a response
	logic       aw_hs;
	logic       b_ok;
	logic       b_bad;   // error response or one nobody asked for

	assign aw_hs   = awvalid && awready;
	assign b_ok    = bvalid && (bresp == 2'b00);
	assign b_bad   = bvalid && ((bresp != 2'b00) || (out_cnt == '0));
	assign drained = (out_cnt == '0);

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			out_cnt   <= '0;
			bus_error <= 1'b0;
		end else begin
			unique case ({aw_hs, b_ok})
				2'b10:   out_cnt <= out_cnt + 1'b1;
				2'b01:   out_cnt <= out_cnt - 1'b1;
				default: out_cnt <= out_cnt; // both or neither
			endcase
			if (b_bad) bus_error <= 1'b1;
		end
	end

	// slave never answers a write it has not accepted
	a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
		b_ok |-> out_cnt != '0);

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the page-table write manager testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_pgwr_mngr \
	-f filelist.f -Mdir obj_dir -o sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^TESTS PASSED$" "$LOG"; then
	exit 0
fi
exit 1

// ==== tests/tb_axi_mem.sv ====
// single-beat AXI write slave, one address latched at a time
// ready signals stall at random by an LCG, bvalid comes 1 to 3 cycles after the beat
// table lines start filled with an address-derived pattern, other lines read as zero
`timescale 1ns/1ps

module tb_axi_mem (
	input  logic              clk_i,
	input  logic              rst_ni,
	input  logic              awvalid,
	input  pgwr_pkg::addr_t   awaddr,
	input  logic              wvalid,
	input  pgwr_pkg::line_t   wdata,
	input  pgwr_pkg::strb_t   wstrb,
	output logic              awready,
	output logic              wready,
	output logic              bvalid,
	output logic [1:0]        bresp
);
	import pgwr_pkg::*;

	line_t           mem [addr_t]; // sparse, keyed by line address
	int unsigned     wr_cnt;       // data beats accepted
	logic [31:0]     seed;
	addr_t           aw_addr_q;
	longint unsigned cyc;
	longint unsigned due;
	longint unsigned last_due;
	longint unsigned due_q [$];    // cycles at which a response goes out

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// junk line, every address bit shows up in the pattern
	function automatic line_t fill_line(input addr_t a);
		return {8{a ^ 64'h5a5a_c3c3_0f0f_9696}};
	endfunction

	task automatic merge_beat();
		line_t ln;
		ln = mem.exists(aw_addr_q) ? mem[aw_addr_q] : '0;
		for (int b = 0; b < LINE_BYTES; b++)
			if (wstrb[b]) ln[b*8 +: 8] = wdata[b*8 +: 8];
		mem[aw_addr_q] = ln;
	endtask

	initial begin
		awready  = 1'b0;
		wready   = 1'b0;
		bvalid   = 1'b0;
		bresp    = 2'b00; // always OKAY
		seed     = 32'd82;
		wr_cnt   = 0;
		cyc      = 0;
		last_due = 0;
		for (int i = 0; i < 4; i++) begin // junk the init passes must overwrite
			mem[ATT_BASE + i * LINE_BYTES]  = fill_line(ATT_BASE + i * LINE_BYTES);
			mem[LIST_BASE + i * LINE_BYTES] = fill_line(LIST_BASE + i * LINE_BYTES);
		end
	end

	always @(posedge clk_i) begin
		if (!rst_ni) begin
			awready = 1'b0;
			wready  = 1'b0;
			bvalid  = 1'b0;
		end else begin
			cyc++;
			if (awvalid && awready) aw_addr_q = awaddr; // pre-edge values
			if (wvalid && wready) begin
				merge_beat();
				wr_cnt++;
				seed = lcg_next(seed);
				due  = cyc + 1 + (seed[17:16] % 3);
				if (due <= last_due) due = last_due + 1; // keep one response per cycle
				last_due = due;
				due_q.push_back(due);
			end
			#2;
			bvalid = (due_q.size() != 0) && (due_q[0] <= cyc);
			if (bvalid) void'(due_q.pop_front());
			seed    = lcg_next(seed);
			awready = (seed[17:16] != 2'b00); // about 3 in 4 cycles ready
			wready  = (seed[19:18] != 2'b00);
		end
	end

endmodule

// ==== tests/tb_pgwr_mngr.sv ====
// runs ATT init, list init and 16 allocations until the free list is empty
// expected table contents come from a list model kept in this module
`timescale 1ns/1ps

module tb_pgwr_mngr;
	import pgwr_pkg::*;

	localparam int MAX_WR      = ATT_ENTRY_CNT + LIST_ENTRY_CNT + 4 * LIST_ENTRY_CNT;
	localparam int TIMEOUT_CYC = MAX_WR * 30 + 500; // 30 cycles per write under stalls

	logic clk_i, rst_ni, init_att, init_list, upd_valid;
	att_id_t upd_att_id;
	ppn_t upd_way;
	ptr_t upd_next;
	logic ready, upd_done, init_att_done, init_list_done, bus_error;
	logic awvalid, awready, wvalid, wready, bvalid;
	logic [1:0] bresp;
	addr_t awaddr;
	line_t wdata;
	strb_t wstrb;
	ptr_t free_head, free_tail, uncomp_head, uncomp_tail;

	// list model
	logic [STS_W-1:0] m_sts [1:ATT_ENTRY_CNT];
	ppn_t    m_att_way [1:ATT_ENTRY_CNT];
	ptr_t    m_next [1:LIST_ENTRY_CNT];
	ptr_t    m_prev [1:LIST_ENTRY_CNT];
	att_id_t m_attid [1:LIST_ENTRY_CNT];
	ppn_t    m_way [1:LIST_ENTRY_CNT];
	ptr_t    m_fh, m_ft, m_uh, m_ut;

	int unsigned errors = 0;
	int unsigned checks = 0;
	int unsigned cyc = 0;
	bit chk_req = 1'b0; // hands a full compare to the compare process

	pgwr_mngr dut (.*);
	tb_axi_mem u_mem (.*);

	initial begin
		clk_i = 1'b0;
		forever #10 clk_i = ~clk_i;
	end

	task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	// expected entry image, att in the low 64 bits
	function automatic logic [127:0] ref_entry(input bit is_list, input int i);
		logic [127:0] e;
		e = '0;
		if (is_list) begin
			e[NEXT_LSB +: PTR_W]  = m_next[i];
			e[PREV_LSB +: PTR_W]  = m_prev[i];
			e[ATTID_LSB +: PTR_W] = m_attid[i];
			e[WAY_LSB_L +: WAY_W] = m_way[i];
		end else begin
			e[STS_LSB +: STS_W] = m_sts[i];
			e[WAY_LSB +: WAY_W] = m_att_way[i];
		end
		return e;
	endfunction

	function automatic logic [127:0] mem_entry(input bit is_list, input int i);
		int    per;
		addr_t a;
		line_t ln;
		per = is_list ? LST_PER_LINE : ATT_PER_LINE;
		a   = (is_list ? LIST_BASE : ATT_BASE) + addr_t'((i - 1) / per) * LINE_BYTES;
		ln  = u_mem.mem.exists(a) ? u_mem.mem[a] : '0;
		ln  = ln >> (((i - 1) % per) * (LINE_BYTES * 8 / per));
		return is_list ? ln[127:0] : {64'h0, ln[63:0]};
	endfunction

	// compare process, whole tables plus pointers and status
	initial begin
		forever begin
			wait (chk_req);
			for (int i = 1; i <= ATT_ENTRY_CNT; i++)
				check($sformatf("att[%0d]", i), mem_entry(1'b0, i), ref_entry(1'b0, i));
			for (int i = 1; i <= LIST_ENTRY_CNT; i++)
				check($sformatf("list[%0d]", i), mem_entry(1'b1, i), ref_entry(1'b1, i));
			check("free_head", free_head, m_fh);
			check("free_tail", free_tail, m_ft);
			check("uncomp_head", uncomp_head, m_uh);
			check("uncomp_tail", uncomp_tail, m_ut);
			check("ready", ready, 1'b1);
			check("bus_error", bus_error, 1'b0);
			check("init_att_done", init_att_done, 1'b1); // sticky
			check("init_list_done", init_list_done, 1'b1);
			chk_req = 1'b0;
		end
	end

	task automatic compare_all();
		chk_req = 1'b1;
		wait (!chk_req);
	endtask

	task automatic model_alloc(input att_id_t id, input ppn_t way);
		ptr_t mv;
		mv = m_fh; // old free head moves
		m_sts[id]     = STS_UNCOMP;
		m_att_way[id] = way;
		if (m_fh == m_ft) begin
			m_fh = NULL_PTR;
			m_ft = NULL_PTR;
		end else begin
			m_fh = m_next[mv];
			m_prev[m_fh] = NULL_PTR;
		end
		m_prev[mv]  = m_ut;
		m_next[mv]  = NULL_PTR;
		m_attid[mv] = id;
		if (m_ut == NULL_PTR) m_uh = mv;
		else m_next[m_ut] = mv;
		m_ut = mv;
	endtask

	task automatic run_alloc(input att_id_t id, input ppn_t way);
		int unsigned wr0;
		int unsigned exp_wr;
		exp_wr = 2 + (m_fh != m_ft) + (m_ut != NULL_PTR); // pop and link optional
		wr0    = u_mem.wr_cnt;
		while (!ready) begin
			@(posedge clk_i);
			#2;
		end
		upd_valid  = 1'b1;
		upd_att_id = id;
		upd_way    = way;
		upd_next   = m_next[m_fh];
		@(posedge clk_i);
		#2;
		upd_valid = 1'b0;
		while (!upd_done) begin
			@(posedge clk_i);
			#2;
		end
		model_alloc(id, way);
		check("alloc write count", u_mem.wr_cnt - wr0, exp_wr);
		compare_all();
	endtask

	initial begin
		int unsigned wr0;
		init_att   = 1'b0;
		init_list  = 1'b0;
		upd_valid  = 1'b0;
		upd_att_id = '0;
		upd_way    = '0;
		upd_next   = '0;
		rst_ni     = 1'b0;
		for (int i = 1; i <= ATT_ENTRY_CNT; i++) begin
			m_sts[i]     = STS_DALLOC;
			m_att_way[i] = '0;
		end
		for (int i = 1; i <= LIST_ENTRY_CNT; i++) begin
			m_next[i]  = ptr_t'(i == LIST_ENTRY_CNT ? 0 : i + 1);
			m_prev[i]  = ptr_t'(i - 1);
			m_attid[i] = '0;
			m_way[i]   = PPN_BASE + ppn_t'(i - 1);
		end
		m_fh = NULL_PTR;
		m_ft = NULL_PTR;
		m_uh = NULL_PTR;
		m_ut = NULL_PTR;
		repeat (5) @(posedge clk_i);
		#2;
		rst_ni = 1'b1;
		check("ready after reset", ready, 1'b1);
		check("free_head after reset", free_head, NULL_PTR);
		check("free_tail after reset", free_tail, NULL_PTR);
		check("uncomp_head after reset", uncomp_head, NULL_PTR);
		check("uncomp_tail after reset", uncomp_tail, NULL_PTR);
		check("awvalid after reset", awvalid, 1'b0);
		check("wvalid after reset", wvalid, 1'b0);
		check("upd_done after reset", upd_done, 1'b0);
		check("init_att_done after reset", init_att_done, 1'b0);
		check("init_list_done after reset", init_list_done, 1'b0);
		check("bus_error after reset", bus_error, 1'b0);

		wr0      = u_mem.wr_cnt;
		init_att = 1'b1; // left high, must not be served twice
		while (!init_att_done) begin
			@(posedge clk_i);
			#2;
		end
		check("att init write count", u_mem.wr_cnt - wr0, ATT_ENTRY_CNT);

		wr0       = u_mem.wr_cnt;
		init_list = 1'b1;
		while (!init_list_done) begin
			@(posedge clk_i);
			#2;
		end
		check("list init write count", u_mem.wr_cnt - wr0, LIST_ENTRY_CNT);
		m_fh = ptr_t'(1);
		m_ft = ptr_t'(LIST_ENTRY_CNT);
		compare_all();

		// last pass hands out the lone free entry
		for (int k = 1; k <= LIST_ENTRY_CNT; k++)
			run_alloc(att_id_t'((k * 5) % ATT_ENTRY_CNT + 1),
				32'h4000_0000 + k * 32'h0101_0101);

		repeat (10) @(posedge clk_i);
		#2;
		check("bus_error at end", bus_error, 1'b0);
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	initial begin
		while (cyc < TIMEOUT_CYC) begin
			@(posedge clk_i);
			cyc++;
		end
		$display("timeout after %0d cycles, the DUT did not finish its operations", cyc);
		$display("TESTS FAILED");
		$finish;
	end

endmodule
